/* hdl/mipsPkg.sv */
package mipsPkg;

	// primary opcode field, bits 31:26.
	typedef enum logic [5:0] {
		opSpecial = 6'h00,
		opJ       = 6'h02,
		opJal     = 6'h03,
		opBeq     = 6'h04,
		opBne     = 6'h05,
		opAddiu   = 6'h09,
		opSlti    = 6'h0a,
		opAndi    = 6'h0c,
		opOri     = 6'h0d,
		opXori    = 6'h0e,
		opLui     = 6'h0f,
		opLb      = 6'h20,
		opLw      = 6'h23,
		opLbu     = 6'h24,
		opSb      = 6'h28,
		opSw      = 6'h2b
	} opcodeT;

	// function field of special instructions, bits 5:0.
	typedef enum logic [5:0] {
		fnSll  = 6'h00,
		fnSrl  = 6'h02,
		fnSra  = 6'h03,
		fnJr   = 6'h08,
		fnAddu = 6'h21,
		fnSubu = 6'h23,
		fnAnd  = 6'h24,
		fnOr   = 6'h25,
		fnXor  = 6'h26,
		fnNor  = 6'h27,
		fnSlt  = 6'h2a,
		fnSltu = 6'h2b
	} functT;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
		aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
	} aluOpT;

	typedef enum logic [1:0] {wbAlu, wbMem, wbLink} wbSrcT;

	typedef enum logic [1:0] {sizeWord, sizeByteSigned, sizeByteUnsigned} memSizeT;

	// branch kind carried from decode into execute.
	typedef enum logic [1:0] {brNone, brEq, brNe, brJump} branchT;

	// operand source in execute.
	typedef enum logic [1:0] {fwdReg, fwdMem, fwdWb} fwdSelT;

endpackage

/* hdl/fetchUnit.sv */
`timescale 1ns/1ps

module fetchUnit #(
	parameter logic [31:0] resetPc = 32'hBFC00000
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        redirect,
	input  logic [31:0] target,
	output logic        instSramEn,
	output logic [31:0] instSramAddr,
	output logic [31:0] pc,
	output logic [31:0] pcPlus4,
	output logic        squash
);

	logic [31:0] nextPc;
	logic        started;

	// pc is the address of the word arriving from the SRAM this cycle.
	assign pcPlus4 = pc + 32'd4;

	always_comb begin
		if (redirect)
			nextPc = target;
		else if (stall)
			nextPc = pc; // fetch the held word again.
		else
			nextPc = pcPlus4;
	end

	assign instSramEn   = 1'b1;
	assign instSramAddr = nextPc;

	// the word behind the delay slot, and the one read during reset, are dropped.
	assign squash = redirect | ~started;

	always_ff @(posedge clk) begin
		if (rst) begin
			pc      <= resetPc - 32'd4;
			started <= 1'b0;
		end else begin
			pc      <= nextPc;
			started <= 1'b1;
		end
	end

endmodule

/* hdl/regFile.sv */
`timescale 1ns/1ps

module regFile (
	input  logic        clk,
	input  logic        rst,
	input  logic [4:0]  raddrA,
	input  logic [4:0]  raddrB,
	input  logic        wbWrite,
	input  logic [4:0]  wbDest,
	input  logic [31:0] wbData,
	output logic [31:0] rdataA,
	output logic [31:0] rdataB
);

	logic [31:0] regs [1:31]; // $0 has no storage.

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < 32; i++)
				regs[i] <= '0;
		end else if (wbWrite && wbDest != 5'd0) begin
			regs[wbDest] <= wbData;
		end
	end

	// a write in the same cycle passes straight to the read port.
	assign rdataA = (raddrA == 5'd0) ? 32'd0 :
	                (wbWrite && wbDest == raddrA) ? wbData : regs[raddrA];
	assign rdataB = (raddrB == 5'd0) ? 32'd0 :
	                (wbWrite && wbDest == raddrB) ? wbData : regs[raddrB];

endmodule

/* hdl/decodeUnit.sv */
`timescale 1ns/1ps

module decodeUnit import mipsPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        stall,
	input  logic        squash,
	input  logic [31:0] instSramRdata,
	input  logic [31:0] pc,
	input  logic [31:0] pcPlus4,
	input  logic [31:0] rdataA,
	input  logic [31:0] rdataB,
	output logic [4:0]  raddrA,
	output logic [4:0]  raddrB,
	output aluOpT       exAluOp,
	output logic        exAluSrcImm,
	output logic        exRegWrite,
	output wbSrcT       exWbSrc,
	output logic        exMemRead,
	output logic        exMemWrite,
	output memSizeT     exMemSize,
	output logic [4:0]  exDest,
	output logic [4:0]  exRs,
	output logic [4:0]  exRt,
	output logic [31:0] exOpA,
	output logic [31:0] exOpB,
	output logic [31:0] exImm,
	output logic [4:0]  exShamt,
	output logic [31:0] exPc,
	output branchT      exBranch,
	output logic        exJumpReg,
	output logic [31:0] exJumpTarget
);

	logic        idValid;
	logic [31:0] idInst;
	logic [31:0] idPc;
	logic [31:0] idPcPlus4;

	opcodeT      opcode;
	functT       funct;
	aluOpT       aluOp;
	wbSrcT       wbSrc;
	memSizeT     memSize;
	branchT      branch;
	logic        valid, aluSrcImm, regWrite, memRead, memWrite;
	logic        signExt, usesRs, usesRt, jumpReg;
	logic [4:0]  dest;
	logic [31:0] imm;

	always_ff @(posedge clk) begin
		if (rst)
			idValid <= 1'b0;
		else if (!stall)
			idValid <= !squash;
	end

	always_ff @(posedge clk) begin
		if (!stall) begin
			idInst    <= instSramRdata;
			idPc      <= pc;
			idPcPlus4 <= pcPlus4;
		end
	end

	assign opcode = opcodeT'(idInst[31:26]);
	assign funct  = functT'(idInst[5:0]);

	always_comb begin
		valid     = idValid;
		aluOp     = aluAdd;
		aluSrcImm = 1'b1;
		regWrite  = 1'b1;
		wbSrc     = wbAlu;
		memRead   = 1'b0;
		memWrite  = 1'b0;
		memSize   = sizeWord;
		signExt   = 1'b1;
		usesRs    = 1'b1;
		usesRt    = 1'b0;
		dest      = idInst[20:16];
		branch    = brNone;
		jumpReg   = 1'b0;
		case (opcode)
			opSpecial: begin
				aluSrcImm = 1'b0;
				usesRt    = 1'b1;
				dest      = idInst[15:11];
				case (funct)
					fnSll:  aluOp = aluSll;
					fnSrl:  aluOp = aluSrl;
					fnSra:  aluOp = aluSra;
					fnAddu: aluOp = aluAdd;
					fnSubu: aluOp = aluSub;
					fnAnd:  aluOp = aluAnd;
					fnOr:   aluOp = aluOr;
					fnXor:  aluOp = aluXor;
					fnNor:  aluOp = aluNor;
					fnSlt:  aluOp = aluSlt;
					fnSltu: aluOp = aluSltu;
					fnJr: begin
						regWrite = 1'b0;
						usesRt   = 1'b0;
						branch   = brJump;
						jumpReg  = 1'b1;
					end
					default: valid = 1'b0;
				endcase
			end
			opJ, opJal: begin
				regWrite = (opcode == opJal);
				usesRs   = 1'b0;
				branch   = brJump;
				wbSrc    = wbLink;
				dest     = 5'd31;
			end
			opBeq, opBne: begin
				regWrite = 1'b0;
				usesRt   = 1'b1;
				branch   = (opcode == opBeq) ? brEq : brNe;
			end
			opAddiu: aluOp = aluAdd;
			opSlti:  aluOp = aluSlt;
			opAndi, opOri, opXori: begin
				signExt = 1'b0;
				aluOp   = (opcode == opAndi) ? aluAnd : (opcode == opOri) ? aluOr : aluXor;
			end
			opLui: begin
				aluOp  = aluLui;
				usesRs = 1'b0;
			end
			opLw, opLb, opLbu: begin
				memRead = 1'b1;
				wbSrc   = wbMem;
				memSize = (opcode == opLw) ? sizeWord :
				          (opcode == opLb) ? sizeByteSigned : sizeByteUnsigned;
			end
			opSw, opSb: begin
				regWrite = 1'b0;
				memWrite = 1'b1;
				usesRt   = 1'b1;
				memSize  = (opcode == opSw) ? sizeWord : sizeByteUnsigned;
			end
			default: valid = 1'b0; // unknown opcodes run as no-ops.
		endcase
	end

	// unused fields read $0 so they never cause a stall.
	assign raddrA = (valid && usesRs) ? idInst[25:21] : 5'd0;
	assign raddrB = (valid && usesRt) ? idInst[20:16] : 5'd0;
	assign imm    = signExt ? {{16{idInst[15]}}, idInst[15:0]} : {16'd0, idInst[15:0]};

	always_ff @(posedge clk) begin
		if (rst || stall || !valid) begin
			exRegWrite <= 1'b0;
			exMemRead  <= 1'b0;
			exMemWrite <= 1'b0;
			exBranch   <= brNone;
		end else begin
			exRegWrite <= regWrite;
			exMemRead  <= memRead;
			exMemWrite <= memWrite;
			exBranch   <= branch;
		end
	end

	always_ff @(posedge clk) begin
		exAluOp      <= aluOp;
		exAluSrcImm  <= aluSrcImm;
		exWbSrc      <= wbSrc;
		exMemSize    <= memSize;
		exDest       <= dest;
		exRs         <= raddrA;
		exRt         <= raddrB;
		exOpA        <= rdataA;
		exOpB        <= rdataB;
		exImm        <= imm;
		exShamt      <= idInst[10:6];
		exPc         <= idPc;
		exJumpReg    <= jumpReg;
		exJumpTarget <= {idPcPlus4[31:28], idInst[25:0], 2'b00};
	end

endmodule

/* hdl/hazardUnit.sv */
`timescale 1ns/1ps

module hazardUnit import mipsPkg::*; (
	input  logic [4:0] idRs,
	input  logic [4:0] idRt,
	input  logic       exMemRead,
	input  logic [4:0] exDest,
	input  logic [4:0] exRs,
	input  logic [4:0] exRt,
	input  logic       memRegWrite,
	input  logic [4:0] memDest,
	input  logic       wbWrite,
	input  logic [4:0] wbDest,
	output logic       stall,
	output fwdSelT     fwdA,
	output fwdSelT     fwdB
);

	logic memLive;
	logic wbLive;

	assign memLive = memRegWrite && memDest != 5'd0;
	assign wbLive  = wbWrite && wbDest != 5'd0;

	// load data only exists in write-back, one cycle too late for execute.
	assign stall = exMemRead && exDest != 5'd0 && (exDest == idRs || exDest == idRt);

	// the memory stage holds the younger result and wins.
	always_comb begin
		fwdA = fwdReg;
		if (memLive && memDest == exRs)
			fwdA = fwdMem;
		else if (wbLive && wbDest == exRs)
			fwdA = fwdWb;
	end

	always_comb begin
		fwdB = fwdReg;
		if (memLive && memDest == exRt)
			fwdB = fwdMem;
		else if (wbLive && wbDest == exRt)
			fwdB = fwdWb;
	end

endmodule

/* hdl/executeUnit.sv */
`timescale 1ns/1ps

module executeUnit import mipsPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  aluOpT       exAluOp,
	input  logic        exAluSrcImm,
	input  logic        exRegWrite,
	input  wbSrcT       exWbSrc,
	input  logic        exMemRead,
	input  logic        exMemWrite,
	input  memSizeT     exMemSize,
	input  logic [4:0]  exDest,
	input  logic [4:0]  exShamt,
	input  logic [31:0] exOpA, exOpB, exImm, exPc, exJumpTarget,
	input  branchT      exBranch,
	input  logic        exJumpReg,
	input  fwdSelT      fwdA, fwdB,
	input  logic [31:0] memFwdData, wbData,
	output logic        redirect,
	output logic [31:0] target,
	output logic        dataSramEn,
	output logic [3:0]  dataSramWen,
	output logic [31:0] dataSramAddr, dataSramWdata,
	output logic        memRegWrite,
	output wbSrcT       memWbSrc,
	output logic        memMemRead,
	output memSizeT     memSize,
	output logic [4:0]  memDest,
	output logic [31:0] memAluOut,
	output logic [1:0]  memByteSel,
	output logic [31:0] memPc
);

	logic [31:0] srcA, srcB, aluB, aluOut, branchTarget;
	logic [3:0]  laneWen;

	function automatic logic [31:0] pickOperand(input fwdSelT sel, input logic [31:0] regVal,
			input logic [31:0] memVal, input logic [31:0] wbVal);
		case (sel)
			fwdMem:  return memVal;
			fwdWb:   return wbVal;
			default: return regVal;
		endcase
	endfunction

	assign srcA = pickOperand(fwdA, exOpA, memFwdData, wbData);
	assign srcB = pickOperand(fwdB, exOpB, memFwdData, wbData);
	assign aluB = exAluSrcImm ? exImm : srcB;

	always_comb begin
		case (exAluOp)
			aluSub:  aluOut = srcA - aluB;
			aluAnd:  aluOut = srcA & aluB;
			aluOr:   aluOut = srcA | aluB;
			aluXor:  aluOut = srcA ^ aluB;
			aluNor:  aluOut = ~(srcA | aluB);
			aluSlt:  aluOut = {31'd0, $signed(srcA) < $signed(aluB)};
			aluSltu: aluOut = {31'd0, srcA < aluB};
			aluSll:  aluOut = aluB << exShamt;
			aluSrl:  aluOut = aluB >> exShamt;
			aluSra:  aluOut = $signed(aluB) >>> exShamt;
			aluLui:  aluOut = {aluB[15:0], 16'd0};
			default: aluOut = srcA + aluB;
		endcase
	end

	always_comb begin
		case (exBranch)
			brEq:    redirect = (srcA == srcB);
			brNe:    redirect = (srcA != srcB);
			brJump:  redirect = 1'b1;
			default: redirect = 1'b0;
		endcase
	end

	assign branchTarget = exPc + 32'd4 + {exImm[29:0], 2'b00};
	assign target = exJumpReg ? srcA : (exBranch == brJump) ? exJumpTarget : branchTarget;

	// sb writes one lane picked by the low address bits.
	assign laneWen = (exMemSize == sizeWord) ? 4'b1111 : 4'b0001 << aluOut[1:0];

	always_ff @(posedge clk) begin
		if (rst) begin
			dataSramEn  <= 1'b0;
			dataSramWen <= 4'd0;
			memRegWrite <= 1'b0;
			memMemRead  <= 1'b0;
		end else begin
			dataSramEn  <= exMemRead | exMemWrite;
			dataSramWen <= exMemWrite ? laneWen : 4'd0;
			memRegWrite <= exRegWrite;
			memMemRead  <= exMemRead;
		end
	end

	always_ff @(posedge clk) begin
		dataSramAddr  <= {aluOut[31:2], 2'b00};
		dataSramWdata <= (exMemSize == sizeWord) ? srcB : {4{srcB[7:0]}};
		memWbSrc      <= exWbSrc;
		memSize       <= exMemSize;
		memDest       <= exDest;
		memAluOut     <= (exWbSrc == wbLink) ? exPc + 32'd8 : aluOut; // jal link value.
		memByteSel    <= aluOut[1:0];
		memPc         <= exPc;
	end

endmodule

/* hdl/resultUnit.sv */
`timescale 1ns/1ps

module resultUnit import mipsPkg::*; (
	input  logic        clk,
	input  logic        rst,
	input  logic        memRegWrite,
	input  wbSrcT       memWbSrc,
	input  logic        memMemRead,
	input  memSizeT     memSize,
	input  logic [4:0]  memDest,
	input  logic [31:0] memAluOut,
	input  logic [1:0]  memByteSel,
	input  logic [31:0] memPc,
	input  logic [31:0] dataSramRdata,
	output logic [31:0] memFwdData,
	output logic        wbWrite,
	output logic [4:0]  wbDest,
	output logic [31:0] wbData,
	output logic [31:0] debugWbPc,
	output logic [3:0]  debugWbRfWen,
	output logic [4:0]  debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);

	wbSrcT       wbSrc;
	memSizeT     wbSize;
	logic [1:0]  wbByteSel;
	logic [31:0] wbAluOut;
	logic [31:0] wbPc;
	logic [31:0] loadData;
	logic [7:0]  loadByte;

	// a load never sits here with a consumer in execute, the stall sees to that.
	assign memFwdData = memAluOut;

	always_ff @(posedge clk) begin
		if (rst)
			wbWrite <= 1'b0;
		else
			wbWrite <= memRegWrite;
	end

	always_ff @(posedge clk) begin
		wbSrc    <= memWbSrc;
		wbDest   <= memDest;
		wbAluOut <= memAluOut;
		wbPc     <= memPc;
		if (memMemRead) begin
			wbSize    <= memSize;
			wbByteSel <= memByteSel;
		end
	end

	// the SRAM answers the load during this stage.
	assign loadByte = dataSramRdata[{wbByteSel, 3'b000} +: 8];

	always_comb begin
		case (wbSize)
			sizeByteSigned:   loadData = {{24{loadByte[7]}}, loadByte};
			sizeByteUnsigned: loadData = {24'd0, loadByte};
			default:          loadData = dataSramRdata;
		endcase
	end

	assign wbData = (wbSrc == wbMem) ? loadData : wbAluOut; // alu and link share a path.

	assign debugWbPc      = wbPc;
	assign debugWbRfWen   = {4{wbWrite && wbDest != 5'd0}};
	assign debugWbRfWnum  = wbDest;
	assign debugWbRfWdata = wbData;

endmodule

/* hdl/mipsCore.sv */
`timescale 1ns/1ps

module mipsCore import mipsPkg::*; #(
	parameter logic [31:0] resetPc = 32'hBFC00000
) (
	input  logic        clk,
	input  logic        rst,
	output logic        instSramEn,
	output logic [31:0] instSramAddr,
	input  logic [31:0] instSramRdata,
	output logic        dataSramEn,
	output logic [3:0]  dataSramWen,
	output logic [31:0] dataSramAddr,
	output logic [31:0] dataSramWdata,
	input  logic [31:0] dataSramRdata,
	output logic [31:0] debugWbPc,
	output logic [3:0]  debugWbRfWen,
	output logic [4:0]  debugWbRfWnum,
	output logic [31:0] debugWbRfWdata
);

	// fetch and control between stages.
	logic [31:0] pc, pcPlus4, target;
	logic        squash, stall, redirect;

	logic [4:0]  raddrA, raddrB;
	logic [31:0] rdataA, rdataB;

	// ID/EX.
	aluOpT       exAluOp;
	logic        exAluSrcImm, exRegWrite, exMemRead, exMemWrite, exJumpReg;
	wbSrcT       exWbSrc;
	memSizeT     exMemSize;
	logic [4:0]  exDest, exRs, exRt, exShamt;
	logic [31:0] exOpA, exOpB, exImm, exPc, exJumpTarget;
	branchT      exBranch;
	fwdSelT      fwdA, fwdB;

	// EX/MEM.
	logic        memRegWrite, memMemRead;
	wbSrcT       memWbSrc;
	memSizeT     memSize;
	logic [4:0]  memDest;
	logic [31:0] memAluOut, memPc, memFwdData;
	logic [1:0]  memByteSel;

	logic        wbWrite;
	logic [4:0]  wbDest;
	logic [31:0] wbData;

	fetchUnit #(.resetPc(resetPc)) uFetch (.*);

	regFile uRegFile (.*);

	decodeUnit uDecode (.*);

	hazardUnit uHazard (
		.idRs(raddrA),
		.idRt(raddrB),
		.*
	);

	executeUnit uExecute (.*);

	resultUnit uResult (.*);

endmodule

/* tests/mipsCore_sva.sv */
`timescale 1ns/1ps

module mipsCoreSva (
	input logic        clk,
	input logic        rst,
	input logic [31:0] instSramAddr,
	input logic        dataSramEn,
	input logic [3:0]  dataSramWen,
	input logic [3:0]  debugWbRfWen,
	input logic [4:0]  debugWbRfWnum
);

	int failCount = 0; // checked by the testbench at the end.

	wenNeedsEn: assert property (@(posedge clk) disable iff (rst)
		dataSramWen != 4'd0 |-> dataSramEn)
		else begin
			failCount++;
			$error("data SRAM byte write enable raised while dataSramEn is low");
		end

	wbWenWhole: assert property (@(posedge clk) disable iff (rst)
		debugWbRfWen == 4'b0000 || debugWbRfWen == 4'b1111)
		else begin
			failCount++;
			$error("debugWbRfWen is neither all ones nor all zeros");
		end

	noZeroWrite: assert property (@(posedge clk) disable iff (rst)
		debugWbRfWen != 4'd0 |-> debugWbRfWnum != 5'd0)
		else begin
			failCount++;
			$error("write-back to register 0 shown on the debug port");
		end

	fetchAligned: assert property (@(posedge clk) disable iff (rst)
		instSramAddr[1:0] == 2'b00)
		else begin
			failCount++;
			$error("instSramAddr is not word aligned");
		end

endmodule

bind mipsCore mipsCoreSva uSva (.*);

/* tests/mipsCoreTb.sv */
`timescale 1ns/1ps

module mipsCoreTb;

	localparam logic [31:0] resetPc = 32'hBFC00000;
	localparam int romDepth = 128;
	localparam int ramDepth = 1024;

	logic        clk = 1'b0;
	logic        rst;
	logic        instSramEn, dataSramEn;
	logic [31:0] instSramAddr, instSramRdata, instNext;
	logic [3:0]  dataSramWen, debugWbRfWen;
	logic [31:0] dataSramAddr, dataSramWdata, dataSramRdata, dataNext;
	logic [31:0] debugWbPc, debugWbRfWdata;
	logic [4:0]  debugWbRfWnum;

	logic [31:0] rom [romDepth];
	logic [31:0] ram [ramDepth];

	// program table in ROM order; skipped and store entries expect no write-back.
	logic [31:0] progInst[$];
	bit          progWr[$];
	logic [4:0]  progReg[$];
	logic [31:0] progVal[$];
	int progLen = 0;
	int expectCount = 0;
	int seenCount = 0;
	int nextStep = 0;

	mipsCore #(.resetPc(resetPc)) u_dut (.*);

	always #5 clk = ~clk;

	function automatic logic [31:0] rType(input logic [5:0] fn, input logic [4:0] rd, rs, rt, sh);
		return {6'h00, rs, rt, rd, sh, fn};
	endfunction

	function automatic logic [31:0] iType(input logic [5:0] op, input logic [4:0] rt, rs,
			input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jType(input logic [5:0] op, input int idx);
		logic [31:0] dest;
		dest = resetPc + 4 * idx; // jump to table entry idx.
		return {op, dest[27:2]};
	endfunction

	function automatic logic [31:0] romWord(input logic [31:0] addr);
		logic [31:0] offset;
		offset = addr - resetPc;
		return (offset < 4 * romDepth) ? rom[offset[31:2]] : 32'd0; // zero is a nop.
	endfunction

	task automatic addStep(input logic [31:0] inst, input logic [4:0] rd, input logic [31:0] val);
		progInst.push_back(inst);
		progWr.push_back(1'b1);
		progReg.push_back(rd);
		progVal.push_back(val);
		expectCount++;
	endtask

	task automatic addQuiet(input logic [31:0] inst);
		progInst.push_back(inst);
		progWr.push_back(1'b0);
		progReg.push_back(5'd0);
		progVal.push_back(32'd0);
	endtask

	task automatic stopRun();
		$display("SIMULATION FAILED");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		assert (got === exp) else begin
			$display("mismatch at %0d ns: %s is %h, expected %h", $time, name, got, exp);
			stopRun();
		end
	endtask

	task automatic buildProgram();
		addStep(iType(6'h09, 1, 0, 16'h0005), 1, 32'h00000005);    // addiu $1, $0, 5
		addStep(iType(6'h09, 2, 0, 16'hFFFD), 2, 32'hFFFFFFFD);    // addiu $2, $0, -3
		addStep(rType(6'h21, 3, 1, 2, 0), 3, 32'h00000002);        // addu from mem and wb.
		addStep(rType(6'h23, 4, 1, 2, 0), 4, 32'h00000008);        // subu
		addStep(rType(6'h2a, 5, 2, 1, 0), 5, 32'h00000001);        // slt -3 < 5
		addStep(rType(6'h2b, 6, 2, 1, 0), 6, 32'h00000000);        // sltu
		addStep(iType(6'h0a, 7, 2, 16'hFFFE), 7, 32'h00000001);    // slti -3 < -2
		addStep(iType(6'h0f, 8, 0, 16'h8765), 8, 32'h87650000);    // lui
		addStep(iType(6'h0d, 8, 8, 16'h4321), 8, 32'h87654321);    // ori
		addStep(rType(6'h03, 9, 0, 8, 4), 9, 32'hF8765432);        // sra
		addStep(rType(6'h02, 10, 0, 8, 8), 10, 32'h00876543);      // srl
		addStep(rType(6'h00, 11, 0, 8, 12), 11, 32'h54321000);     // sll
		addStep(rType(6'h27, 12, 8, 0, 0), 12, 32'h789ABCDE);      // nor
		addStep(iType(6'h0c, 13, 8, 16'hFF0F), 13, 32'h00004301);  // andi, zero extended.
		addStep(iType(6'h0e, 14, 2, 16'h00F0), 14, 32'hFFFFFF0D);  // xori
		addStep(rType(6'h26, 15, 8, 12, 0), 15, 32'hFFFFFFFF);     // xor
		addStep(rType(6'h25, 16, 1, 4, 0), 16, 32'h0000000D);      // or
		addStep(rType(6'h24, 17, 8, 15, 0), 17, 32'h87654321);     // and
		addQuiet(iType(6'h09, 0, 0, 16'h0007));                    // write to $0.
		addStep(rType(6'h21, 18, 0, 1, 0), 18, 32'h00000005);      // $0 still reads zero.
		addStep(iType(6'h09, 19, 0, 16'h0100), 19, 32'h00000100);  // data base address
		addQuiet(iType(6'h2b, 8, 19, 16'h0000));                   // sw $8, 0($19)
		addQuiet(iType(6'h2b, 2, 19, 16'h0004));                   // sw $2, 4($19)
		addQuiet(iType(6'h28, 1, 19, 16'h0005));                   // sb $1, 5($19)
		addStep(iType(6'h23, 20, 19, 16'h0000), 20, 32'h87654321); // lw
		addStep(iType(6'h20, 21, 19, 16'h0003), 21, 32'hFFFFFF87); // lb, sign extended.
		addStep(iType(6'h24, 22, 19, 16'h0003), 22, 32'h00000087); // lbu
		addStep(iType(6'h23, 23, 19, 16'h0004), 23, 32'hFFFF05FD); // lw sees the sb lane.
		addStep(rType(6'h21, 24, 23, 1, 0), 24, 32'hFFFF0602);     // load-use stall.
		addStep(iType(6'h20, 25, 19, 16'h0005), 25, 32'h00000005); // lb
		addStep(rType(6'h23, 26, 0, 25, 0), 26, 32'hFFFFFFFB);     // load-use on rt.
		addQuiet(iType(6'h04, 18, 1, 16'h0002));                   // beq taken to 34.
		addStep(iType(6'h09, 27, 0, 16'h0001), 27, 32'h00000001);  // delay slot
		addQuiet(iType(6'h09, 28, 0, 16'h0BAD));                   // squashed
		addQuiet(iType(6'h05, 18, 1, 16'h0005));                   // bne not taken.
		addStep(iType(6'h09, 27, 27, 16'h0001), 27, 32'h00000002); // delay slot
		addStep(iType(6'h09, 27, 27, 16'h0001), 27, 32'h00000003); // fall through
		addStep(jType(6'h03, 40), 31, resetPc + 32'd156);          // jal links pc + 8.
		addStep(iType(6'h09, 28, 0, 16'h0011), 28, 32'h00000011);  // delay slot
		addQuiet(iType(6'h09, 28, 0, 16'h0BAD));                   // squashed
		addStep(iType(6'h0f, 29, 0, 16'hBFC0), 29, 32'hBFC00000);  // lui
		addStep(iType(6'h0d, 29, 29, 16'h00B8), 29, 32'hBFC000B8); // address of entry 46
		addQuiet(rType(6'h08, 0, 29, 0, 0));                       // jr $29
		addStep(rType(6'h21, 30, 31, 0, 0), 30, resetPc + 32'd156); // delay slot reads $31.
		addQuiet(iType(6'h09, 30, 0, 16'h0BAD));                   // squashed
		addQuiet(iType(6'h09, 30, 0, 16'h0BAD));                   // never fetched
		addQuiet(jType(6'h02, 49));                                // j
		addStep(iType(6'h09, 3, 3, 16'h0001), 3, 32'h00000003);    // delay slot
		addQuiet(iType(6'h09, 3, 0, 16'h0BAD));                    // squashed
		addQuiet(iType(6'h05, 1, 3, 16'h0002));                    // bne taken to 52.
		addStep(iType(6'h09, 4, 4, 16'h0001), 4, 32'h00000009);    // delay slot
		addQuiet(iType(6'h09, 4, 0, 16'h0BAD));                    // squashed
		addQuiet(iType(6'h04, 0, 4, 16'h0003));                    // beq not taken.
		addStep(rType(6'h21, 5, 4, 5, 0), 5, 32'h0000000A);        // delay slot
		addStep(rType(6'h27, 6, 0, 0, 0), 6, 32'hFFFFFFFF);        // nor of $0
		progLen = progInst.size();
	endtask

	// both SRAM models sample the request mid-cycle and answer one cycle later.
	always @(negedge clk) begin
		instSramRdata <= instNext;
		if (instSramEn)
			instNext <= romWord(instSramAddr);
	end

	always @(negedge clk) begin
		dataSramRdata <= dataNext;
		if (dataSramEn) begin
			dataNext <= ram[dataSramAddr[11:2]];
			for (int b = 0; b < 4; b++)
				if (dataSramWen[b])
					ram[dataSramAddr[11:2]][8*b +: 8] <= dataSramWdata[8*b +: 8];
		end
	end

	// write-backs must match the table entries that expect one, in order.
	always @(posedge clk) begin
		if (!rst && debugWbRfWen != 4'd0) begin
			while (nextStep < progLen && !progWr[nextStep])
				nextStep++;
			assert (nextStep < progLen) else begin
				$display("register %0d written at %0d ns after the last expected write-back",
					debugWbRfWnum, $time);
				stopRun();
			end
			checkValue("debugWbPc", debugWbPc, resetPc + 4 * nextStep);
			checkValue("debugWbRfWnum", debugWbRfWnum, progReg[nextStep]);
			checkValue("debugWbRfWdata", debugWbRfWdata, progVal[nextStep]);
			nextStep++;
			seenCount++;
		end
	end

	initial begin
		wait (progLen > 0);
		repeat (20 * progLen + 100) @(posedge clk);
		$display("watchdog expired with %0d of %0d write-backs seen", seenCount, expectCount);
		stopRun();
	end

	initial begin
		rst = 1'b1;
		instSramRdata = 32'd0;
		dataSramRdata = 32'd0;
		void'($urandom(78136));
		for (int i = 0; i < ramDepth; i++)
			ram[i] = $urandom;
		for (int i = 0; i < romDepth; i++)
			rom[i] = 32'd0;
		buildProgram();
		for (int i = 0; i < progLen; i++)
			rom[i] = progInst[i];
		repeat (3) @(negedge clk);
		rst = 1'b0;
		wait (seenCount == expectCount);
		repeat (10) @(negedge clk); // room for a stray write-back to show up.
		if (u_dut.uSva.failCount == 0) begin
			$display("SIMULATION PASSED");
			$finish;
		end else begin
			$display("%0d bound assertion failures", u_dut.uSva.failCount);
			stopRun();
		end
	end

endmodule

/* sources.f */
hdl/mipsPkg.sv
hdl/fetchUnit.sv
hdl/regFile.sv
hdl/decodeUnit.sv
hdl/hazardUnit.sv
hdl/executeUnit.sv
hdl/resultUnit.sv
hdl/mipsCore.sv
tests/mipsCore_sva.sv
tests/mipsCoreTb.sv

/* Bender.yml */
package:
  name: mipscore

sources:
  - hdl/mipsPkg.sv
  - hdl/fetchUnit.sv
  - hdl/regFile.sv
  - hdl/decodeUnit.sv
  - hdl/hazardUnit.sv
  - hdl/executeUnit.sv
  - hdl/resultUnit.sv
  - hdl/mipsCore.sv
  - target: test
    files:
      - tests/mipsCore_sva.sv
      - tests/mipsCoreTb.sv
